/* Bender.yml */
package:
  name: wrapper_conv2d

sources:
  - include_dirs:
      - .
    files:
      - conv_pkg.sv
      - pin_stage_regs.sv
      - conv2d_ctrl.sv
      - tcdm_port_select.sv
      - wrapper_conv2d.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_wrapper_conv2d.sv

/* conv2d_ctrl.sv */
// Phase sequencer; zero geometry is not supported and local addresses wrap at 4096 words.
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv2d_ctrl (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start2d,
	input  conv_pkg::dim_t       width,
	input  conv_pkg::dim_t       height,
	input  conv_pkg::dim_t       channels,
	input  conv_pkg::dim_t       filters,
	input  conv_pkg::npix_t      total_pixels,
	input  conv_pkg::ext_bases_t bases,
	input  conv_pkg::word_t      pixel_rdata,
	input  conv_pkg::word_t      bias_rdata,
	input  conv_pkg::word_t      coef1_rdata,
	input  conv_pkg::mac_bank_t  mac_din,
	input  logic                 tcdm1_gnt,
	input  logic                 tcdm2_gnt,
	input  logic                 tcdm3_gnt,
	input  logic [15:0]          quant,
	input  logic [2:0]           shift,
	output logic                 done2d,
	output logic                 csel,
	output logic                 sat,
	output logic [1:0]           math_mode,
	output logic [5:0]           outsel,
	output logic                 mac_clr,
	output logic                 mac_clken,
	output logic                 pixel_wen,
	output logic                 filter1_wen,
	output logic                 filter2_wen,
	output logic                 bias_wen,
	output conv_pkg::laddr_t     bias_raddr,
	output conv_pkg::laddr_t     bias_waddr,
	output conv_pkg::laddr_t     pixel_raddr,
	output conv_pkg::laddr_t     pixel_waddr,
	output conv_pkg::laddr_t     filter_raddr,
	output conv_pkg::laddr_t     filter_waddr,
	output conv_pkg::word_t      pixel_wdata,
	output conv_pkg::word_t      filter_wdata,
	output conv_pkg::word_t      bias_wdata,
	output conv_pkg::word_t      result_wdata,
	output conv_pkg::tcdm_req_t  port1,
	output conv_pkg::tcdm_req_t  port2,
	output conv_pkg::tcdm_req_t  port3,
	output logic [15:0]          debug
);

	conv_pkg::ctrl_state_t state;
	logic [`CONV_ADDR_W-1:0] wcnt;
	logic [`CONV_ADDR_W-1:0] wlimit;
	logic [`CONV_ADDR_W-1:0] n_filt;
	conv_pkg::npix_t mcnt;
	conv_pkg::npix_t n_mac;
	conv_pkg::tcdm_addr_t woff;
	conv_pkg::laddr_t waddr;
	conv_pkg::laddr_t pptr;
	conv_pkg::laddr_t fptr;
	conv_pkg::laddr_t plane;
	conv_pkg::word_t pixel_hold;
	conv_pkg::word_t filter_hold;
	conv_pkg::word_t bias_hold;
	logic [1:0] kx;
	logic [1:0] ky;
	logic f_gnt;
	logic adv;
	logic wlast;

	assign n_filt = {11'd0, filters} * {11'd0, channels} * 20'd3; // Three row words per channel.
	assign n_mac = {7'd0, channels} * 16'd9;
	assign plane = {3'd0, width} * {3'd0, height};

	always_comb begin
		case (state)
			conv_pkg::LOAD_BIAS: wlimit = {11'd0, filters};
			conv_pkg::LOAD_FILTER: wlimit = n_filt;
			default: wlimit = {4'd0, total_pixels};
		endcase
	end

	assign wlast = (wcnt == wlimit - 20'd1);
	assign woff = conv_pkg::tcdm_addr_t'(wcnt * `CONV_WORD_STRIDE);
	assign waddr = conv_pkg::laddr_t'(wcnt);

	always_comb begin
		port1.req = (state == conv_pkg::LOAD_FILTER) || (state == conv_pkg::LOAD_PIXEL);
		port1.wen = 1'b1;
		port1.addr = (state == conv_pkg::LOAD_PIXEL) ? bases.pixel + woff : bases.filter + woff;
		port2.req = (state == conv_pkg::STORE);
		port2.wen = 1'b0; // Result writes.
		port2.addr = bases.result + woff;
		port3.req = (state == conv_pkg::LOAD_BIAS);
		port3.wen = 1'b1;
		port3.addr = bases.bias + woff;
	end

	assign f_gnt = (state == conv_pkg::LOAD_FILTER) && tcdm1_gnt;
	assign bias_wen = (state == conv_pkg::LOAD_BIAS) && tcdm3_gnt;
	assign filter1_wen = f_gnt && !wcnt[0];
	assign filter2_wen = f_gnt && wcnt[0];
	assign pixel_wen = (state == conv_pkg::LOAD_PIXEL) && tcdm1_gnt;
	assign adv = bias_wen || f_gnt || pixel_wen || (port2.req && tcdm2_gnt);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= conv_pkg::IDLE;
			wcnt <= '0;
			mcnt <= '0;
		end else begin
			if (adv)
				wcnt <= wlast ? '0 : wcnt + 20'd1;
			case (state)
				conv_pkg::IDLE: if (start2d) state <= conv_pkg::LOAD_BIAS;
				conv_pkg::LOAD_BIAS: if (adv && wlast) state <= conv_pkg::LOAD_FILTER;
				conv_pkg::LOAD_FILTER: if (adv && wlast) state <= conv_pkg::LOAD_PIXEL;
				conv_pkg::LOAD_PIXEL: if (adv && wlast) state <= conv_pkg::COMPUTE;
				conv_pkg::COMPUTE: begin
					mcnt <= (mcnt == n_mac) ? '0 : mcnt + 16'd1;
					if (mcnt == n_mac)
						state <= conv_pkg::STORE;
				end
				conv_pkg::STORE: if (adv) state <= wlast ? conv_pkg::DONE : conv_pkg::COMPUTE;
				default: state <= conv_pkg::IDLE;
			endcase
		end
	end

	// Window walk over the 3x3 taps of each channel plane.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pptr <= '0;
			fptr <= '0;
			kx <= '0;
			ky <= '0;
		end else if (mac_clr) begin
			pptr <= waddr;
			fptr <= '0;
			kx <= '0;
			ky <= '0;
		end else if (mac_clken) begin
			if (kx != 2'd2) begin
				pptr <= pptr + 12'd1;
				kx <= kx + 2'd1;
			end else begin
				kx <= '0;
				fptr <= fptr + 12'd1; // Next filter row word.
				if (ky != 2'd2) begin
					pptr <= pptr + conv_pkg::laddr_t'(width) - 12'd2;
					ky <= ky + 2'd1;
				end else begin
					pptr <= pptr + plane - conv_pkg::laddr_t'(width) * 12'd2 - 12'd2;
					ky <= '0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (bias_wen)
			bias_hold <= bias_rdata;
		if (f_gnt)
			filter_hold <= coef1_rdata;
		if (pixel_wen)
			pixel_hold <= pixel_rdata;
	end

	assign bias_wdata = bias_wen ? bias_rdata : bias_hold;
	assign filter_wdata = f_gnt ? coef1_rdata : filter_hold;
	assign pixel_wdata = pixel_wen ? pixel_rdata : pixel_hold;
	assign result_wdata = mac_din[3:0]; // Slot 0 in the low byte.

	assign mac_clr = (state == conv_pkg::COMPUTE) && (mcnt == '0);
	assign mac_clken = (state == conv_pkg::COMPUTE) && (mcnt != '0);
	assign pixel_raddr = pptr;
	assign filter_raddr = fptr;
	assign bias_raddr = waddr;
	assign bias_waddr = waddr;
	assign pixel_waddr = waddr;
	assign filter_waddr = waddr;

	assign done2d = (state == conv_pkg::DONE);
	assign csel = (state == conv_pkg::COMPUTE);
	assign sat = (state == conv_pkg::STORE);
	assign outsel = wcnt[5:0];

	always_comb begin
		case (state)
			conv_pkg::LOAD_BIAS, conv_pkg::LOAD_FILTER, conv_pkg::LOAD_PIXEL: math_mode = 2'd1;
			conv_pkg::COMPUTE: math_mode = 2'd2;
			conv_pkg::STORE: math_mode = 2'd3;
			default: math_mode = 2'd0;
		endcase
	end

	assign debug = {state, quant[9:0], shift};

	a_wen_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({pixel_wen, filter1_wen, filter2_wen, bias_wen}));

	// A waiting request keeps its address until its own grant.
	a_port1_hold: assert property (@(posedge clk) disable iff (!rst_n)
		port1.req && !tcdm1_gnt |=> port1.req && $stable(port1.addr));
	a_port2_hold: assert property (@(posedge clk) disable iff (!rst_n)
		port2.req && !tcdm2_gnt |=> port2.req && $stable(port2.addr));
	a_port3_hold: assert property (@(posedge clk) disable iff (!rst_n)
		port3.req && !tcdm3_gnt |=> port3.req && $stable(port3.addr));

endmodule

/* conv_defs.svh */
// Bus widths and pin selector codes; addresses assume byte addressing with 32-bit words.
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// TCDM byte address and local buffer address widths.
`define CONV_ADDR_W 20
`define CONV_LADDR_W 12
`define CONV_DATA_W 32
`define CONV_DIM_W 9
`define CONV_NPIX_W 16
`define CONV_MAC_W 8
`define CONV_MAC_N 8

// Codes of select_ext_base_temp.
`define CONV_SEL_FILTER_BASE 2'd0
`define CONV_SEL_PIXEL_BASE 2'd1
`define CONV_SEL_BIAS_BASE 2'd2
`define CONV_SEL_RESULT_BASE 2'd3

`define CONV_WORD_STRIDE 4

`endif

/* conv_pkg.sv */
// Shared types of the wrapper; all widths come from conv_defs.svh.
`include "conv_defs.svh"

package conv_pkg;

	typedef logic [`CONV_ADDR_W-1:0] tcdm_addr_t;
	typedef logic [`CONV_LADDR_W-1:0] laddr_t;
	typedef logic [`CONV_DATA_W-1:0] word_t;
	typedef logic [`CONV_DIM_W-1:0] dim_t;
	typedef logic [`CONV_MAC_W-1:0] mac_byte_t;
	typedef logic [`CONV_NPIX_W-1:0] npix_t;

	// Phases run in this order.
	typedef enum logic [2:0] {
		IDLE,
		LOAD_BIAS,
		LOAD_FILTER,
		LOAD_PIXEL,
		COMPUTE,
		STORE,
		DONE
	} ctrl_state_t;

	// wen high is a read.
	typedef struct packed {
		logic req;
		logic wen;
		tcdm_addr_t addr;
	} tcdm_req_t;

	typedef struct packed {
		tcdm_addr_t filter;
		tcdm_addr_t pixel;
		tcdm_addr_t bias;
		tcdm_addr_t result;
	} ext_bases_t;

	typedef mac_byte_t [`CONV_MAC_N-1:0] mac_bank_t;

endpackage

/* pin_stage_regs.sv */
// Staged values update one cycle after the pins; only the selected slot changes each cycle.
`timescale 1ns/1ps
`include "conv_defs.svh"

module pin_stage_regs (
	input  logic                   clk,
	input  logic                   rst_n,
	input  conv_pkg::tcdm_addr_t   ext_base_temp,
	input  logic [1:0]             select_ext_base_temp,
	input  conv_pkg::word_t        rdata_temp,
	input  logic [1:0]             select_rdata_temp,
	input  conv_pkg::mac_byte_t    mac_temp_din,
	input  logic [2:0]             select_mac_temp_din,
	input  logic [1:0]             select_pixel_filter_temp,
	input  conv_pkg::laddr_t       filter_raddr,
	input  conv_pkg::laddr_t       filter_waddr,
	input  conv_pkg::laddr_t       pixel_raddr,
	input  conv_pkg::laddr_t       pixel_waddr,
	output conv_pkg::ext_bases_t   bases,
	output conv_pkg::word_t        pixel_rdata,
	output conv_pkg::word_t        bias_rdata,
	output conv_pkg::word_t        coef1_rdata,
	output conv_pkg::word_t        coef2_rdata,
	output conv_pkg::mac_bank_t    mac_din,
	output conv_pkg::laddr_t       temp_addr
);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bases <= '0;
			pixel_rdata <= '0;
			bias_rdata <= '0;
			coef1_rdata <= '0;
			coef2_rdata <= '0;
			mac_din <= '0;
			temp_addr <= '0;
		end else begin
			case (select_ext_base_temp)
				`CONV_SEL_FILTER_BASE: bases.filter <= ext_base_temp;
				`CONV_SEL_PIXEL_BASE: bases.pixel <= ext_base_temp;
				`CONV_SEL_BIAS_BASE: bases.bias <= ext_base_temp;
				`CONV_SEL_RESULT_BASE: bases.result <= ext_base_temp;
			endcase

			case (select_rdata_temp)
				2'd0: pixel_rdata <= rdata_temp;
				2'd1: bias_rdata <= rdata_temp;
				2'd2: coef2_rdata <= rdata_temp;
				2'd3: coef1_rdata <= rdata_temp;
			endcase

			mac_din[select_mac_temp_din] <= mac_temp_din; // One MAC byte per cycle.

			// Local address made visible on the 12-bit pin.
			case (select_pixel_filter_temp)
				2'd0: temp_addr <= filter_raddr;
				2'd1: temp_addr <= filter_waddr;
				2'd2: temp_addr <= pixel_raddr;
				2'd3: temp_addr <= pixel_waddr;
			endcase
		end
	end

endmodule

/* src.f */
+incdir+.
conv_pkg.sv
pin_stage_regs.sv
conv2d_ctrl.sv
tcdm_port_select.sv
wrapper_conv2d.sv
tb_wrapper_conv2d.sv

/* tb_wrapper_conv2d.sv */
// Vectors come from wrapper_conv2d_tests.txt, which must hold exactly NUM_TESTS lines of 19 hex words.
`timescale 1ns/1ps
`include "conv_defs.svh"

module tb_wrapper_conv2d;

	localparam int NUM_TESTS = 4;
	localparam int NUM_COLS = 19;

	logic clk = 1'b0;
	logic rst_n, start2d, done2d, csel, sat, mac_clr, mac_clken;
	logic pixel_wen, filter1_wen, filter2_wen, bias_wen;
	logic tcdm_temp_req, tcdm_temp_wen, tcdm1_gnt, tcdm1_valid, tcdm2_gnt, tcdm2_valid, tcdm3_gnt;
	logic [1:0] math_mode, select_ext_base_temp, select_pixel_filter_temp, select_rdata_temp;
	logic [5:0] outsel;
	logic [2:0] sel_mux_data_32, select_mac_temp_din, shift;
	logic [15:0] quant, debug;
	conv_pkg::dim_t width, height, channels, filters;
	conv_pkg::npix_t total_pixels;
	conv_pkg::tcdm_addr_t ext_base_temp, tcdm_temp_addr;
	conv_pkg::laddr_t bias_raddr, bias_waddr, temp_addr;
	conv_pkg::word_t mux_data_32, rdata_temp, tcdm_temp_rdata;
	conv_pkg::mac_byte_t mac_temp_din;

	logic [31:0] vec [0:NUM_TESTS*NUM_COLS-1];
	int cycles = 0;
	int limit = 0;

	wrapper_conv2d uut (.*);

	always #50 clk = ~clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic compare_addr(input string name, input conv_pkg::tcdm_addr_t got,
			input conv_pkg::tcdm_addr_t exp);
		if (got !== exp)
			fail_run($sformatf("error %s got %h expected %h", name, got, exp));
	endtask

	task automatic compare_word(input string name, input conv_pkg::word_t got,
			input conv_pkg::word_t exp);
		if (got !== exp)
			fail_run($sformatf("error %s got %h expected %h", name, got, exp));
	endtask

	task automatic compare_laddr(input string name, input conv_pkg::laddr_t got,
			input conv_pkg::laddr_t exp);
		if (got !== exp)
			fail_run($sformatf("error %s got %h expected %h", name, got, exp));
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("error %s got %h expected %h", name, got, exp));
	endtask

	task automatic compare_state(input string name, input conv_pkg::ctrl_state_t got,
			input conv_pkg::ctrl_state_t exp);
		if (got !== exp)
			fail_run($sformatf("error %s got %h expected %h", name, got, exp));
	endtask

	task automatic compare_shift(input string name, input logic [2:0] got, input logic [2:0] exp);
		if (got !== exp)
			fail_run($sformatf("error %s got %h expected %h", name, got, exp));
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles > limit)
			fail_run("timeout, the controller never finished the test sequence");
	end

	task automatic run_test(input int t);
		int b, c, f, np, nf, stall, cand, gap;
		int bcnt, fcnt, pcnt, scnt, clr_cnt, clken_cnt, exp_mode;
		logic grant, exp_req, exp_wen, taddr_on, done_exp, done_seen;
		conv_pkg::tcdm_addr_t fb, pb, bb, rb, exp_addr;
		conv_pkg::laddr_t exp_taddr;
		conv_pkg::ctrl_state_t exp_state;
		conv_pkg::word_t staged [4];
		b = t * NUM_COLS;
		c = int'(vec[b+2]);
		f = int'(vec[b+3]);
		np = int'(vec[b+4]);
		nf = f * c * 3;
		fb = conv_pkg::tcdm_addr_t'(vec[b+5]);
		pb = conv_pkg::tcdm_addr_t'(vec[b+6]);
		bb = conv_pkg::tcdm_addr_t'(vec[b+7]);
		rb = conv_pkg::tcdm_addr_t'(vec[b+8]);
		stall = int'(vec[b+17]);
		// Bases, read words and MAC bytes go in over four cycles; the last slot keeps its value.
		for (int i = 0; i < 4; i++) begin
			@(negedge clk);
			width = conv_pkg::dim_t'(vec[b]);
			height = conv_pkg::dim_t'(vec[b+1]);
			channels = conv_pkg::dim_t'(c);
			filters = conv_pkg::dim_t'(f);
			total_pixels = conv_pkg::npix_t'(np);
			shift = 3'(t + 1);
			select_pixel_filter_temp = 2'(vec[b+16]);
			select_ext_base_temp = 2'(i);
			ext_base_temp = conv_pkg::tcdm_addr_t'(vec[b+5+i]);
			select_mac_temp_din = 3'(i);
			mac_temp_din = conv_pkg::mac_byte_t'(vec[b+12+i]);
			select_rdata_temp = (i == 0) ? 2'd0 : (i == 1) ? 2'd3 : 2'd1;
			rdata_temp = (i == 0) ? vec[b+10] : (i == 1) ? vec[b+11] : vec[b+9];
		end
		// Staged coef1, coef2, pixel and bias words on debug codes 4 to 7; coef2 is never loaded.
		staged[0] = vec[b+11];
		staged[1] = '0;
		staged[2] = vec[b+10];
		staged[3] = vec[b+9];
		for (int s = 0; s < 4; s++) begin
			@(negedge clk);
			sel_mux_data_32 = 3'(s + 4);
			#10;
			compare_word("mux_data_32", mux_data_32, staged[s]);
		end
		@(negedge clk);
		start2d = 1'b1;
		@(negedge clk);
		start2d = 1'b0;
		bcnt = 0;
		fcnt = 0;
		pcnt = 0;
		scnt = 0;
		clr_cnt = 0;
		clken_cnt = 0;
		gap = 0;
		exp_mode = 0;
		taddr_on = 1'b0;
		done_exp = 1'b0;
		done_seen = 1'b0;
		while (!done_seen) begin
			cand = 0;
			if (bcnt < f) begin
				sel_mux_data_32 = 3'd1;
				exp_state = conv_pkg::LOAD_BIAS;
				cand = 3;
			end else if (fcnt < nf) begin
				sel_mux_data_32 = 3'd3;
				exp_state = conv_pkg::LOAD_FILTER;
				cand = 1;
			end else if (pcnt < np) begin
				sel_mux_data_32 = 3'd2;
				exp_state = conv_pkg::LOAD_PIXEL;
				cand = 1;
			end else begin
				sel_mux_data_32 = 3'd0;
				if (scnt == np)
					exp_state = conv_pkg::DONE;
				else if (clken_cnt == (scnt + 1) * c * 9) begin
					exp_state = conv_pkg::STORE; // All MAC cycles of this pixel are over.
					cand = 2;
				end else
					exp_state = conv_pkg::COMPUTE;
			end
			grant = 1'b0;
			if (cand != 0) begin
				if (gap == 0) begin
					grant = 1'b1;
					gap = int'($urandom % (stall + 1)); // Stall before the next grant.
				end else
					gap--;
			end
			tcdm1_gnt = grant && cand == 1;
			tcdm1_valid = tcdm1_gnt;
			tcdm2_gnt = grant && cand == 2;
			tcdm2_valid = tcdm2_gnt;
			tcdm3_gnt = grant && cand == 3;
			#10;
			// Shared pins and temp_addr show what the previous cycle selected.
			if (exp_mode == 1) begin
				compare_bit("tcdm_temp_req", tcdm_temp_req, exp_req);
				compare_bit("tcdm_temp_wen", tcdm_temp_wen, exp_wen);
				compare_addr("tcdm_temp_addr", tcdm_temp_addr, exp_addr);
			end else if (exp_mode == 2)
				compare_bit("tcdm_temp_req", tcdm_temp_req, 1'b0);
			if (taddr_on)
				compare_laddr("temp_addr", temp_addr, exp_taddr);
			compare_bit("done2d", done2d, done_exp);
			compare_state("debug", conv_pkg::ctrl_state_t'(debug[15:13]), exp_state);
			compare_shift("debug", debug[2:0], shift);
			done_seen = done2d;
			done_exp = 1'b0;
			taddr_on = 1'b0;
			exp_mode = 2;
			exp_req = 1'b1;
			exp_wen = 1'b1;
			compare_bit("mac_clr", mac_clr && mac_clken, 1'b0);
			if (mac_clr)
				clr_cnt++;
			if (mac_clken)
				clken_cnt++;
			if (bias_wen) begin
				compare_laddr("bias_waddr", bias_waddr, conv_pkg::laddr_t'(bcnt));
				compare_word("mux_data_32", mux_data_32, vec[b+9]);
				exp_mode = 1;
				exp_addr = bb + conv_pkg::tcdm_addr_t'(4 * bcnt);
				taddr_on = 1'b1;
				exp_taddr = conv_pkg::laddr_t'(bcnt);
				bcnt++;
			end else if (filter1_wen || filter2_wen) begin
				compare_bit("filter1_wen", filter1_wen, (fcnt % 2) == 0);
				compare_bit("filter2_wen", filter2_wen, 1'(fcnt % 2));
				compare_word("mux_data_32", mux_data_32, vec[b+11]);
				exp_mode = 1;
				exp_addr = fb + conv_pkg::tcdm_addr_t'(4 * fcnt);
				taddr_on = 1'b1;
				exp_taddr = conv_pkg::laddr_t'(fcnt);
				fcnt++;
			end else if (pixel_wen) begin
				compare_word("mux_data_32", mux_data_32, vec[b+10]);
				exp_mode = 1;
				exp_addr = pb + conv_pkg::tcdm_addr_t'(4 * pcnt);
				taddr_on = 1'b1;
				exp_taddr = conv_pkg::laddr_t'(pcnt);
				pcnt++;
			end else if (tcdm2_gnt) begin
				compare_word("mux_data_32", mux_data_32, vec[b+18]);
				if (clr_cnt != scnt + 1 || clken_cnt != (scnt + 1) * c * 9)
					fail_run($sformatf("wrong number of MAC clear or enable cycles before result %0d",
						scnt));
				exp_mode = 1;
				exp_wen = 1'b0;
				exp_addr = rb + conv_pkg::tcdm_addr_t'(4 * scnt);
				scnt++;
				done_exp = (scnt == np);
			end else if (bcnt < f) begin
				exp_mode = 1; // Bias request still waiting.
				exp_addr = bb + conv_pkg::tcdm_addr_t'(4 * bcnt);
			end
			if (!done_seen)
				@(negedge clk);
		end
		if (scnt != np)
			fail_run("done2d came before all result words were written");
		@(negedge clk);
		#10;
		compare_bit("done2d", done2d, 1'b0);
		compare_bit("tcdm_temp_req", tcdm_temp_req, 1'b0);
	endtask

	initial begin
		int seed;
		int max_stall;
		int work;
		seed = 11;
		void'($urandom(seed));
		rst_n = 1'b0;
		start2d = 1'b0;
		{width, height, channels, filters} = '0;
		total_pixels = '0;
		ext_base_temp = '0;
		select_ext_base_temp = 2'd0;
		select_pixel_filter_temp = 2'd0;
		select_rdata_temp = 2'd0;
		rdata_temp = '0;
		mac_temp_din = '0;
		select_mac_temp_din = 3'd0;
		sel_mux_data_32 = 3'd0;
		tcdm_temp_rdata = '0;
		{tcdm1_gnt, tcdm1_valid, tcdm2_gnt, tcdm2_valid, tcdm3_gnt} = '0;
		quant = 16'h0000;
		shift = 3'd0;
		$readmemh("wrapper_conv2d_tests.txt", vec);
		work = 0;
		max_stall = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			work += int'(vec[t*NUM_COLS+3]) * (1 + int'(vec[t*NUM_COLS+2]) * 3);
			work += int'(vec[t*NUM_COLS+4]) * (int'(vec[t*NUM_COLS+2]) * 9 + 4);
			if (int'(vec[t*NUM_COLS+17]) > max_stall)
				max_stall = int'(vec[t*NUM_COLS+17]);
		end
		limit = work * (max_stall + 2) + 200;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		#10;
		compare_bit("tcdm_temp_req", tcdm_temp_req, 1'b0);
		compare_bit("done2d", done2d, 1'b0);
		compare_bit("mac_clr", mac_clr, 1'b0);
		compare_bit("mac_clken", mac_clken, 1'b0);
		compare_bit("pixel_wen", pixel_wen, 1'b0);
		compare_bit("filter1_wen", filter1_wen, 1'b0);
		compare_bit("filter2_wen", filter2_wen, 1'b0);
		compare_bit("bias_wen", bias_wen, 1'b0);
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* tcdm_port_select.sv */
// Shared pins lag the selected port by one cycle; port 3 wins whenever ports 1 and 2 are idle.
`timescale 1ns/1ps

module tcdm_port_select (
	input  logic                clk,
	input  logic                rst_n,
	input  conv_pkg::tcdm_req_t port1,
	input  conv_pkg::tcdm_req_t port2,
	input  conv_pkg::tcdm_req_t port3,
	input  logic                tcdm1_gnt,
	input  logic                tcdm1_valid,
	input  logic                tcdm2_gnt,
	input  logic                tcdm2_valid,
	input  conv_pkg::word_t     tcdm_temp_rdata,
	output conv_pkg::tcdm_req_t shared,
	output conv_pkg::word_t     rdata1,
	output conv_pkg::word_t     rdata2,
	output conv_pkg::word_t     rdata3
);

	logic win1;
	logic win2;

	assign win1 = tcdm1_gnt && tcdm1_valid;
	assign win2 = tcdm2_gnt && tcdm2_valid;

	always_ff @(posedge clk) begin
		if (!rst_n)
			shared <= '0;
		else if (win1)
			shared <= port1;
		else if (win2)
			shared <= port2;
		else
			shared <= port3;
	end

	always_ff @(posedge clk) begin
		if (win1)
			rdata1 <= tcdm_temp_rdata;
		else if (win2)
			rdata2 <= tcdm_temp_rdata;
		else
			rdata3 <= tcdm_temp_rdata; // Same priority as the request copy.
	end

	// First copy taken after reset release comes from idle ports.
	a_req_after_reset: assert property (@(posedge clk) $rose(rst_n) |=> !shared.req);

endmodule

/* wrapper_conv2d.sv */
// Pad-limited top; wide operands arrive over several cycles through the staging selectors.
`timescale 1ns/1ps

module wrapper_conv2d (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start2d,
	output logic                 done2d,
	input  conv_pkg::dim_t       width,
	input  conv_pkg::dim_t       height,
	input  conv_pkg::dim_t       channels,
	input  conv_pkg::dim_t       filters,
	input  conv_pkg::tcdm_addr_t ext_base_temp,
	input  logic [1:0]           select_ext_base_temp,
	output logic                 csel,
	output logic                 sat,
	output logic [1:0]           math_mode,
	output logic [5:0]           outsel,
	output logic                 mac_clr,
	output logic                 mac_clken,
	output logic                 pixel_wen,
	output logic                 filter1_wen,
	output logic                 filter2_wen,
	output logic                 bias_wen,
	input  conv_pkg::npix_t      total_pixels,
	output conv_pkg::laddr_t     bias_raddr,
	output conv_pkg::laddr_t     bias_waddr,
	output conv_pkg::laddr_t     temp_addr,
	input  logic [1:0]           select_pixel_filter_temp,
	output conv_pkg::word_t      mux_data_32,
	input  logic [2:0]           sel_mux_data_32,
	input  conv_pkg::word_t      rdata_temp,
	input  logic [1:0]           select_rdata_temp,
	input  conv_pkg::mac_byte_t  mac_temp_din,
	input  logic [2:0]           select_mac_temp_din,
	output conv_pkg::tcdm_addr_t tcdm_temp_addr,
	input  conv_pkg::word_t      tcdm_temp_rdata,
	output logic                 tcdm_temp_req,
	output logic                 tcdm_temp_wen,
	input  logic                 tcdm1_gnt,
	input  logic                 tcdm1_valid,
	input  logic                 tcdm2_gnt,
	input  logic                 tcdm2_valid,
	input  logic                 tcdm3_gnt,
	input  logic [15:0]          quant,
	input  logic [2:0]           shift,
	output logic [15:0]          debug
);

	conv_pkg::ext_bases_t bases;
	conv_pkg::mac_bank_t mac_din;
	conv_pkg::word_t pixel_rdata, bias_rdata, coef1_rdata, coef2_rdata;
	conv_pkg::word_t pixel_wdata, filter_wdata, bias_wdata, result_wdata;
	conv_pkg::laddr_t filter_raddr, filter_waddr, pixel_raddr, pixel_waddr;
	conv_pkg::tcdm_req_t port1, port2, port3, shared;

	pin_stage_regs u_stage (
		.clk, .rst_n, .ext_base_temp, .select_ext_base_temp, .rdata_temp, .select_rdata_temp,
		.mac_temp_din, .select_mac_temp_din, .select_pixel_filter_temp,
		.filter_raddr, .filter_waddr, .pixel_raddr, .pixel_waddr,
		.bases, .pixel_rdata, .bias_rdata, .coef1_rdata, .coef2_rdata, .mac_din, .temp_addr
	);

	conv2d_ctrl u_ctrl (
		.clk, .rst_n, .start2d, .width, .height, .channels, .filters, .total_pixels, .bases,
		.pixel_rdata, .bias_rdata, .coef1_rdata, .mac_din, .tcdm1_gnt, .tcdm2_gnt, .tcdm3_gnt,
		.quant, .shift, .done2d, .csel, .sat, .math_mode, .outsel, .mac_clr, .mac_clken,
		.pixel_wen, .filter1_wen, .filter2_wen, .bias_wen, .bias_raddr, .bias_waddr,
		.pixel_raddr, .pixel_waddr, .filter_raddr, .filter_waddr,
		.pixel_wdata, .filter_wdata, .bias_wdata, .result_wdata,
		.port1, .port2, .port3, .debug
	);

	tcdm_port_select u_psel (
		.clk, .rst_n, .port1, .port2, .port3, .tcdm1_gnt, .tcdm1_valid,
		.tcdm2_gnt, .tcdm2_valid, .tcdm_temp_rdata, .shared,
		.rdata1(), .rdata2(), .rdata3()
	);

	assign tcdm_temp_req = shared.req;
	assign tcdm_temp_wen = shared.wen;
	assign tcdm_temp_addr = shared.addr;

	// Debug view of the write data and staged read words.
	always_comb begin
		case (sel_mux_data_32)
			3'd0: mux_data_32 = result_wdata;
			3'd1: mux_data_32 = bias_wdata;
			3'd2: mux_data_32 = pixel_wdata;
			3'd3: mux_data_32 = filter_wdata;
			3'd4: mux_data_32 = coef1_rdata;
			3'd5: mux_data_32 = coef2_rdata;
			3'd6: mux_data_32 = pixel_rdata;
			default: mux_data_32 = bias_rdata;
		endcase
	end

endmodule

/* wrapper_conv2d_tests.txt */
// width height channels filters pixels filter_base pixel_base bias_base result_base
// bias_word pixel_word coef1_word mac0 mac1 mac2 mac3 temp_sel max_stall expected_result
4 4 1 2 3 01000 02000 03000 04000 11112222 33334444 55556666 01 02 03 04 1 0 04030201
5 3 2 3 4 0a000 0b000 0c000 0d000 deadbeef 0badf00d cafe1234 80 7f ff 00 3 3 00ff7f80
3 3 1 1 1 10000 20000 30000 40000 00000001 80000000 12345678 aa bb cc dd 1 5 ddccbbaa
6 6 3 4 2 fff00 00010 00100 01000 a5a5a5a5 5a5a5a5a 0f0f0f0f 10 20 30 40 3 2 40302010
